//--- tb.f
calc_pkg.sv
addition.sv
multiply.sv
gencon.sv
calculator.sv
tb_clock.sv
calculator_sva.sv
calculator_tb.sv

//--- Makefile
TOP := calculator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module calculator -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- calculator_tb.sv
// Testbench top: types digits and operations into the calculator and checks every result
`timescale 1ns/1ns

module calculator_tb;
    import calc_pkg::*;

    typedef digit_t digit_list_t [5];

    // Directed, ignored strobes, add/sub, multiply and mixed runs
    localparam int NUM_OPS = 77;
    // Ten digits plus the operation stay under 300 cycles
    localparam int WATCHDOG_CYCLES = NUM_OPS * 300 + 500;

    logic clk;
    logic nRST;
    digit_t keypad_input;
    logic read_input;
    op_t operator_input;
    logic equal_input;
    logic complete;
    word_t display_output;

    digit_list_t first_digits;
    digit_list_t second_digits;
    int n_first;
    int n_second;
    op_t cur_op;
    word_t expected_q[$];
    word_t expected_result;
    int results_seen = 0;
    int ops_done = 0;

    tb_clock clock_gen (.clk(clk));

    calculator #(
        .STEP_BITS (4)
    ) calculator_inst (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    // Folds the typed digits as times ten plus digit, modulo 2^16
    function automatic word_t fold_digits(input digit_list_t digs, input int count);
        logic [31:0] acc;
        int i;
        acc = '0;
        for (i = 0; i < count; i++) begin
            acc = (acc * 32'd10 + {28'd0, digs[i]}) & 32'h0000_ffff;
        end
        return acc[15:0];
    endfunction

    function automatic word_t calc_ref(input digit_list_t d1, input int n1,
                                       input digit_list_t d2, input int n2, input op_t op);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = {16'd0, fold_digits(d1, n1)};
        b = {16'd0, fold_digits(d2, n2)};
        case (op)
            OP_ADD: r = a + b;
            OP_SUB: r = a - b;
            OP_MUL: r = a * b;
            default: r = '0;
        endcase
        return r[15:0];
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("FAIL at %0t ns: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    // One strobe, then the 24-cycle gap before the display is read
    task automatic send_digit(input digit_t d);
        @(posedge clk);
        keypad_input <= d;
        read_input   <= 1'b1;
        @(posedge clk);
        read_input   <= 1'b0;
        repeat (23) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic send_operator(input op_t op);
        @(posedge clk);
        operator_input <= op;
        @(posedge clk);
        operator_input <= '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic send_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
    endtask

    task automatic wait_for_result(input int target);
        int waited;
        waited = 0;
        while (results_seen < target && waited < 30) begin
            @(posedge clk);
            waited++;
        end
        if (results_seen < target) begin
            report_failure("No complete within 30 cycles of equal_input");
        end
    endtask

    task automatic set_operands(input digit_list_t d1, input int c1,
                                input digit_list_t d2, input int c2, input op_t op);
        first_digits  = d1;
        n_first       = c1;
        second_digits = d2;
        n_second      = c2;
        cur_op        = op;
    endtask

    // kind 0 is add or subtract, 1 multiply, anything else any operator
    task automatic pick_random(input int kind);
        int i;
        int sel;
        n_first  = 1 + int'($urandom % 5);
        n_second = 1 + int'($urandom % 5);
        for (i = 0; i < 5; i++) begin
            first_digits[i]  = digit_t'($urandom % 10);
            second_digits[i] = digit_t'($urandom % 10);
        end
        sel = (kind == 0) ? int'($urandom % 2) : (kind == 1) ? 2 : int'($urandom % 3);
        case (sel)
            0: cur_op = OP_ADD;
            1: cur_op = OP_SUB;
            default: cur_op = OP_MUL;
        endcase
    endtask

    task automatic run_operation(input logic stray);
        word_t shown;
        int i;
        int target;
        // Equal pulse while the first operand is still open
        if (stray) begin
            @(negedge clk);
            shown = display_output;
            send_equal();
            repeat (24) @(posedge clk);
            @(negedge clk);
            check_value("display_output", display_output, shown);
        end
        for (i = 0; i < n_first; i++) begin
            send_digit(first_digits[i]);
            check_value("display_output", display_output, fold_digits(first_digits, i + 1));
        end
        send_operator(cur_op);
        for (i = 0; i < n_second; i++) begin
            send_digit(second_digits[i]);
            check_value("display_output", display_output, fold_digits(second_digits, i + 1));
            if (stray && i == 0) begin
                send_operator((cur_op == OP_MUL) ? OP_ADD : OP_MUL);
            end
        end
        expected_q.push_back(calc_ref(first_digits, n_first, second_digits, n_second, cur_op));
        target = results_seen + 1;
        send_equal();
        wait_for_result(target);
        ops_done++;
        // A second complete would land here
        repeat (3) @(posedge clk);
    endtask

    initial begin
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        void'($urandom(32'hf54d));
        repeat (3) @(posedge clk);
        nRST <= 1'b1;

        repeat (10) begin
            @(negedge clk);
            check_value("display_output", display_output, '0);
            check_value("complete", word_t'(complete), '0);
        end

        set_operands('{4'd7, 4'd0, 4'd0, 4'd0, 4'd0}, 1,
                     '{4'd5, 4'd0, 4'd0, 4'd0, 4'd0}, 1, OP_ADD);
        run_operation(1'b0);
        set_operands('{4'd3, 4'd0, 4'd0, 4'd0, 4'd0}, 1,
                     '{4'd8, 4'd0, 4'd0, 4'd0, 4'd0}, 1, OP_SUB);
        run_operation(1'b0);
        set_operands('{4'd1, 4'd2, 4'd0, 4'd0, 4'd0}, 2,
                     '{4'd3, 4'd4, 4'd0, 4'd0, 4'd0}, 2, OP_MUL);
        run_operation(1'b0);
        // 99999 wraps past 65535 during entry
        set_operands('{4'd9, 4'd9, 4'd9, 4'd9, 4'd9}, 5,
                     '{4'd1, 4'd0, 4'd0, 4'd0, 4'd0}, 1, OP_ADD);
        run_operation(1'b0);
        set_operands('{4'd6, 4'd5, 4'd5, 4'd3, 4'd5}, 5,
                     '{4'd2, 4'd0, 4'd0, 4'd0, 4'd0}, 1, OP_MUL);
        run_operation(1'b0);
        set_operands('{4'd0, 4'd0, 4'd0, 4'd0, 4'd0}, 1,
                     '{4'd1, 4'd0, 4'd0, 4'd0, 4'd0}, 1, OP_SUB);
        run_operation(1'b0);

        set_operands('{4'd4, 4'd2, 4'd0, 4'd0, 4'd0}, 2,
                     '{4'd1, 4'd7, 4'd0, 4'd0, 4'd0}, 2, OP_SUB);
        run_operation(1'b1);

        repeat (10) begin
            pick_random(0);
            run_operation(1'b0);
        end
        repeat (10) begin
            pick_random(1);
            run_operation(1'b0);
        end
        repeat (50) begin
            pick_random(2);
            run_operation(1'b0);
        end

        if (ops_done == NUM_OPS && results_seen == NUM_OPS && expected_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_failure($sformatf("Ran %0d operations but saw %0d results",
                                     ops_done, results_seen));
        end
    end

    // Every complete must match the oldest pending expected result
    initial begin
        forever begin
            @(negedge clk);
            if (nRST && complete) begin
                if (expected_q.size() == 0) begin
                    report_failure("complete pulsed with no operation waiting for it");
                end else begin
                    expected_result = expected_q.pop_front();
                    check_value("display_output", display_output, expected_result);
                    results_seen = results_seen + 1;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("Watchdog: run hung, still going after %0d cycles",
                                 WATCHDOG_CYCLES));
    end

endmodule

//--- calculator_sva.sv
// Controller assertions for the calculator, bound into gencon by the bind at the end of this file
`timescale 1ns/1ns

module calculator_sva (
    input logic                  clk,
    input logic                  nRST,
    input calc_pkg::ctrl_state_t state,
    input logic                  complete,
    input logic                  add_start,
    input logic                  mul_start,
    input logic                  mul_finish
);
    import calc_pkg::*;

    // Multiplier busy from its start until its finish
    logic mul_busy;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            mul_busy <= 1'b0;
        end else if (mul_start) begin
            mul_busy <= 1'b1;
        end else if (mul_finish) begin
            mul_busy <= 1'b0;
        end
    end

    complete_one_cycle: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else $error("complete stayed high for more than one cycle");

    mul_start_when_idle: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> !mul_busy)
        else $error("mul_start while the multiplier was busy");

    add_start_in_dispatch: assert property (@(posedge clk) disable iff (!nRST)
        add_start |-> state == DISPATCH)
        else $error("add_start outside DISPATCH");

    // Checked from the second sampled cycle of reset on
    complete_low_in_reset: assert property (@(posedge clk)
        !nRST |=> !complete)
        else $error("complete high during reset");

endmodule

bind gencon calculator_sva calculator_sva_inst (
    .clk        (clk),
    .nRST       (nRST),
    .state      (state),
    .complete   (complete),
    .add_start  (add_start),
    .mul_start  (mul_start),
    .mul_finish (mul_finish)
);

//--- tb_clock.sv
// Free-running testbench clock with an 8 ns period; instantiate once in the testbench top
`timescale 1ns/1ns

module tb_clock #(
    parameter int HALF_PERIOD = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end
endmodule

//--- calculator.sv
// Calculator top level joining the controller to the adder and the multiplier
`timescale 1ns/1ns

module calculator #(
    parameter int STEP_BITS = 4
) (
    input  logic             clk,
    input  logic             nRST,
    input  calc_pkg::digit_t keypad_input,
    input  logic             read_input,
    input  calc_pkg::op_t    operator_input,
    input  logic             equal_input,
    output logic             complete,
    output calc_pkg::word_t  display_output
);
    import calc_pkg::*;

    word_t add_a;
    word_t add_b;
    word_t add_out;
    logic add_sub;
    logic add_start;
    logic add_finish;

    word_t mul_a;
    word_t mul_b;
    word_t mul_out;
    logic mul_start;
    logic mul_finish;

    gencon gencon_inst (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .add_a          (add_a),
        .add_b          (add_b),
        .add_sub        (add_sub),
        .add_start      (add_start),
        .add_out        (add_out),
        .add_finish     (add_finish),
        .mul_a          (mul_a),
        .mul_b          (mul_b),
        .mul_start      (mul_start),
        .mul_out        (mul_out),
        .mul_finish     (mul_finish),
        .complete       (complete),
        .display_output (display_output)
    );

    addition #(
        .STEP_BITS (STEP_BITS)
    ) addition_inst (
        .clk    (clk),
        .nRST   (nRST),
        .a      (add_a),
        .b      (add_b),
        .sub    (add_sub),
        .start  (add_start),
        .out    (add_out),
        .finish (add_finish)
    );

    multiply multiply_inst (
        .clk    (clk),
        .nRST   (nRST),
        .a      (mul_a),
        .b      (mul_b),
        .start  (mul_start),
        .out    (mul_out),
        .finish (mul_finish)
    );

endmodule

//--- gencon.sv
// Calculator controller: digit entry through the multiplier, operator capture, unit dispatch
`timescale 1ns/1ns

module gencon (
    input  logic            clk,
    input  logic            nRST,

    input  calc_pkg::digit_t keypad_input,
    input  logic            read_input,
    input  calc_pkg::op_t   operator_input,
    input  logic            equal_input,

    output calc_pkg::word_t add_a,
    output calc_pkg::word_t add_b,
    output logic            add_sub,
    output logic            add_start,
    input  calc_pkg::word_t add_out,
    input  logic            add_finish,

    output calc_pkg::word_t mul_a,
    output calc_pkg::word_t mul_b,
    output logic            mul_start,
    input  calc_pkg::word_t mul_out,
    input  logic            mul_finish,

    output logic            complete,
    output calc_pkg::word_t display_output
);
    import calc_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    word_t operand1;
    word_t operand2;
    digit_t digit_r;
    op_t op_r;
    // Pulses in the first cycle of a scaling state
    logic scale_start;
    logic use_mul;
    logic unit_finish;
    logic digit_taken;

    // Anything but multiply goes to the adder
    assign use_mul = (op_r == OP_MUL);
    assign unit_finish = use_mul ? mul_finish : add_finish;
    assign digit_taken = read_input && (state == ENTER_FIRST || state == ENTER_SECOND);

    always_comb begin
        next_state = state;
        case (state)
            ENTER_FIRST: begin
                if (read_input) begin
                    next_state = SCALE_FIRST;
                end else if (operator_input != '0) begin
                    next_state = ENTER_SECOND;
                end
            end
            SCALE_FIRST: begin
                if (mul_finish) begin
                    next_state = ADD_DIGIT_FIRST;
                end
            end
            ADD_DIGIT_FIRST:
                next_state = ENTER_FIRST;
            ENTER_SECOND: begin
                if (read_input) begin
                    next_state = SCALE_SECOND;
                end else if (equal_input) begin
                    next_state = DISPATCH;
                end
            end
            SCALE_SECOND: begin
                if (mul_finish) begin
                    next_state = ADD_DIGIT_SECOND;
                end
            end
            ADD_DIGIT_SECOND:
                next_state = ENTER_SECOND;
            DISPATCH:
                next_state = WAIT_UNIT;
            WAIT_UNIT: begin
                if (unit_finish) begin
                    next_state = SHOW_RESULT;
                end
            end
            SHOW_RESULT:
                next_state = ENTER_FIRST;
            default:
                next_state = ENTER_FIRST;
        endcase
    end

    // Unit operands only matter in the start cycle
    always_comb begin
        mul_a = operand1;
        mul_b = DIGIT_BASE;
        if (state == SCALE_SECOND) begin
            mul_a = operand2;
        end else if (state == DISPATCH) begin
            mul_b = operand2;
        end
    end

    assign mul_start = scale_start || (state == DISPATCH && use_mul);

    assign add_a     = operand1;
    assign add_b     = operand2;
    assign add_sub   = (op_r == OP_SUB);
    assign add_start = (state == DISPATCH) && !use_mul;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTER_FIRST;
            operand1       <= '0;
            operand2       <= '0;
            op_r           <= '0;
            scale_start    <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state       <= next_state;
            scale_start <= digit_taken;
            complete    <= 1'b0;
            case (state)
                ENTER_FIRST: begin
                    if (!read_input && operator_input != '0) begin
                        op_r     <= operator_input;
                        operand2 <= '0;
                    end
                end
                SCALE_FIRST: begin
                    if (mul_finish) begin
                        operand1 <= mul_out;
                    end
                end
                ADD_DIGIT_FIRST: begin
                    operand1       <= operand1 + word_t'(digit_r);
                    display_output <= operand1 + word_t'(digit_r);
                end
                SCALE_SECOND: begin
                    if (mul_finish) begin
                        operand2 <= mul_out;
                    end
                end
                ADD_DIGIT_SECOND: begin
                    operand2       <= operand2 + word_t'(digit_r);
                    display_output <= operand2 + word_t'(digit_r);
                end
                SHOW_RESULT: begin
                    display_output <= use_mul ? mul_out : add_out;
                    complete       <= 1'b1;
                    operand1       <= '0;
                    operand2       <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    // Digit held until the scaled operand comes back
    always_ff @(posedge clk) begin
        if (digit_taken) begin
            digit_r <= keypad_input;
        end
    end

endmodule

//--- multiply.sv
// Shift-and-add multiplier, one load cycle then 16 iterations; low 16 bits of the product on out
`timescale 1ns/1ns

module multiply (
    input  logic          clk,
    input  logic          nRST,
    input  calc_pkg::word_t a,
    input  calc_pkg::word_t b,
    input  logic          start,
    output calc_pkg::word_t out,
    output logic          finish
);
    import calc_pkg::*;

    localparam int CW = $clog2(WORD_BITS);

    word_t mcand;
    word_t mplier;
    word_t acc;
    logic busy;
    logic [CW-1:0] count;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                // Result lands with the last iteration
                if (count == CW'(WORD_BITS - 1)) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            // Bits shifted past the top are dropped
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign out = acc;

endmodule

//--- addition.sv
// Multi-cycle add/subtract unit, STEP_BITS bits per cycle from the low end; start in, finish out
`timescale 1ns/1ns

module addition #(
    parameter int STEP_BITS = 4
) (
    input  logic          clk,
    input  logic          nRST,
    input  calc_pkg::word_t a,
    input  calc_pkg::word_t b,
    input  logic          sub,
    input  logic          start,
    output calc_pkg::word_t out,
    output logic          finish
);
    import calc_pkg::*;

    localparam int NCHUNK = WORD_BITS / STEP_BITS;
    localparam int CW = (NCHUNK > 1) ? $clog2(NCHUNK) : 1;

    word_t a_r;
    word_t b_r;
    word_t sum_r;
    logic carry;
    logic busy;
    logic [CW-1:0] idx;
    logic [STEP_BITS:0] chunk_sum;

    // One chunk plus the carry from the chunk below
    assign chunk_sum = {1'b0, a_r[idx*STEP_BITS +: STEP_BITS]}
                     + {1'b0, b_r[idx*STEP_BITS +: STEP_BITS]}
                     + {{STEP_BITS{1'b0}}, carry};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            idx    <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                if (idx == CW'(NCHUNK - 1)) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // Subtract as a + ~b + 1
    always_ff @(posedge clk) begin
        if (start) begin
            a_r   <= a;
            b_r   <= sub ? ~b : b;
            carry <= sub;
        end else if (busy) begin
            sum_r[idx*STEP_BITS +: STEP_BITS] <= chunk_sum[STEP_BITS-1:0];
            carry <= chunk_sum[STEP_BITS];
        end
    end

    assign out = sum_r;

endmodule

//--- calc_pkg.sv
// Shared widths, operator codes and controller states for the calculator core; import where needed
package calc_pkg;

    localparam int WORD_BITS = 16;

    // Operands, unit data paths and the display
    typedef logic [WORD_BITS-1:0] word_t;
    // One keypad code
    typedef logic [3:0] digit_t;
    // One-hot operator, zero when none
    typedef logic [2:0] op_t;

    localparam op_t OP_ADD = 3'b001;
    localparam op_t OP_SUB = 3'b010;
    localparam op_t OP_MUL = 3'b100;

    // Entry multiplier for decimal digits
    localparam word_t DIGIT_BASE = 16'd10;

    typedef enum logic [3:0] {
        ENTER_FIRST,
        SCALE_FIRST,
        ADD_DIGIT_FIRST,
        ENTER_SECOND,
        SCALE_SECOND,
        ADD_DIGIT_SECOND,
        DISPATCH,
        WAIT_UNIT,
        SHOW_RESULT
    } ctrl_state_t;

endpackage
